// ==== logic/fetch_pkg.sv ====
// Instruction fetch definitions
package fetch_pkg;

    // Number of words held in the fetch buffer.
    localparam int fetch_buf_depth = 4;

    // Number of execute-permission regions.
    localparam int pmp_regions = 4;

    // Reset program counter.
    localparam logic [31:0] entry_point = 32'h0000_0100;

    // Instruction access fault cause.
    localparam logic [3:0] ecause_iaccess = 4'd1;

    // One 32-bit fetch word.
    // Read as a whole instruction or as two halfwords.
    typedef union packed {
        logic [31:0] full;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } half;
    } insn_word_t;

endpackage

// ==== logic/fetch_buffer.sv ====
// Fetch word buffer
`timescale 1ns/1ps

module fetch_buffer (
    input  logic        clk,
    input  logic        rst,
    input  logic        fence_i,
    input  logic        bus_ready,
    input  logic [31:0] bus_rdata,
    input  logic [31:2] bus_addr,
    input  logic        m_mode,
    input  logic        perm_x,
    output logic [31:0] buf_data   [fetch_pkg::fetch_buf_depth],
    output logic [31:2] buf_addr   [fetch_pkg::fetch_buf_depth],
    output logic        buf_valid  [fetch_pkg::fetch_buf_depth],
    output logic        buf_m_mode [fetch_pkg::fetch_buf_depth],
    output logic        buf_x      [fetch_pkg::fetch_buf_depth]
);

    // Tag of the request answered in this cycle.
    logic [31:2] head_addr;
    logic        head_m_mode;
    logic        head_x;

    // Older words, entry 1 is the most recent.
    logic [31:0] ent_data   [1:fetch_pkg::fetch_buf_depth-1];
    logic [31:2] ent_addr   [1:fetch_pkg::fetch_buf_depth-1];
    logic        ent_valid  [1:fetch_pkg::fetch_buf_depth-1];
    logic        ent_m_mode [1:fetch_pkg::fetch_buf_depth-1];
    logic        ent_x      [1:fetch_pkg::fetch_buf_depth-1];

    // The request is tagged one cycle before its data arrives.
    always_ff @(posedge clk) begin
        head_addr   <= bus_addr;
        head_m_mode <= m_mode;
        head_x      <= perm_x;
    end

    // Entry 0 comes straight from the bus.
    always_comb begin
        buf_data[0]   = bus_rdata;
        buf_valid[0]  = bus_ready;
        buf_addr[0]   = head_addr;
        buf_m_mode[0] = head_m_mode;
        buf_x[0]      = head_x;
        for (int i = 1; i < fetch_pkg::fetch_buf_depth; i++) begin
            buf_data[i]   = ent_data[i];
            buf_addr[i]   = ent_addr[i];
            buf_valid[i]  = ent_valid[i];
            buf_m_mode[i] = ent_m_mode[i];
            buf_x[i]      = ent_x[i];
        end
    end

    // Valid flags shift with each returned word.
    always_ff @(posedge clk) begin
        if (rst || fence_i) begin
            for (int i = 1; i < fetch_pkg::fetch_buf_depth; i++) begin
                ent_valid[i] <= 1'b0;
            end
        end else if (bus_ready) begin
            for (int i = 1; i < fetch_pkg::fetch_buf_depth; i++) begin
                ent_valid[i] <= buf_valid[i-1];
            end
        end
    end

    // Word payload and tags.
    always_ff @(posedge clk) begin
        if (bus_ready) begin
            for (int i = 1; i < fetch_pkg::fetch_buf_depth; i++) begin
                ent_data[i]   <= buf_data[i-1];
                ent_addr[i]   <= buf_addr[i-1];
                ent_m_mode[i] <= buf_m_mode[i-1];
                ent_x[i]      <= buf_x[i-1];
            end
        end
    end

endmodule

// ==== logic/fetch_buffer_reader.sv ====
// Fetch buffer lookup
`timescale 1ns/1ps

module fetch_buffer_reader (
    input  logic                  m_mode,
    input  logic [31:0]           buf_data   [fetch_pkg::fetch_buf_depth],
    input  logic [31:2]           buf_addr   [fetch_pkg::fetch_buf_depth],
    input  logic                  buf_valid  [fetch_pkg::fetch_buf_depth],
    input  logic                  buf_m_mode [fetch_pkg::fetch_buf_depth],
    input  logic                  buf_x      [fetch_pkg::fetch_buf_depth],
    input  logic [31:2]           lookup_addr,
    output logic                  hit,
    output fetch_pkg::insn_word_t rdata,
    output logic                  perm_x
);

    logic [fetch_pkg::fetch_buf_depth-1:0] amatch;
    logic [fetch_pkg::fetch_buf_depth-1:0] amask;

    // Address match, with the mode tag checked on stored words.
    always_comb begin
        for (int i = 0; i < fetch_pkg::fetch_buf_depth; i++) begin
            amatch[i] = buf_valid[i] && buf_addr[i] == lookup_addr;
            if (i > 0) begin
                amatch[i] = amatch[i] && buf_m_mode[i] == m_mode;
            end
        end
    end

    // Keep only the newest match.
    always_comb begin
        logic taken;
        taken = 1'b0;
        for (int i = 0; i < fetch_pkg::fetch_buf_depth; i++) begin
            amask[i] = amatch[i] && !taken;
            taken    = taken || amatch[i];
        end
    end

    // One-hot select by masking and or-reducing.
    always_comb begin
        logic [31:0] word;
        word   = '0;
        perm_x = 1'b0;
        for (int i = 0; i < fetch_pkg::fetch_buf_depth; i++) begin
            word   = word | ({32{amask[i]}} & buf_data[i]);
            perm_x = perm_x | (amask[i] & buf_x[i]);
        end
        rdata.full = word;
    end

    assign hit = |amatch;

endmodule

// ==== logic/exec_permission.sv ====
// Execute permission table
`timescale 1ns/1ps

module exec_permission (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        cfg_we,
    input  logic [$clog2(fetch_pkg::pmp_regions)-1:0]   cfg_index,
    input  logic [31:2]                                 cfg_base,
    input  logic [31:2]                                 cfg_limit,
    input  logic                                        cfg_x,
    input  logic                                        cfg_lock,
    input  logic                                        m_mode,
    input  logic [31:2]                                 check_addr,
    output logic                                        perm_x
);

    // Region bounds are inclusive word addresses.
    logic [31:2] reg_base  [fetch_pkg::pmp_regions];
    logic [31:2] reg_limit [fetch_pkg::pmp_regions];
    logic [fetch_pkg::pmp_regions-1:0] reg_en;
    logic [fetch_pkg::pmp_regions-1:0] reg_x;
    logic [fetch_pkg::pmp_regions-1:0] reg_lock;

    // A written region becomes active.
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_en <= '0;
        end else if (cfg_we) begin
            reg_en[cfg_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            reg_base[cfg_index]  <= cfg_base;
            reg_limit[cfg_index] <= cfg_limit;
            reg_x[cfg_index]     <= cfg_x;
            reg_lock[cfg_index]  <= cfg_lock;
        end
    end

    // Lowest numbered matching region decides.
    always_comb begin
        logic found;
        logic sel_x;
        logic sel_lock;
        found    = 1'b0;
        sel_x    = 1'b0;
        sel_lock = 1'b0;
        for (int i = 0; i < fetch_pkg::pmp_regions; i++) begin
            if (!found && reg_en[i] && check_addr >= reg_base[i]
                    && check_addr <= reg_limit[i]) begin
                found    = 1'b1;
                sel_x    = reg_x[i];
                sel_lock = reg_lock[i];
            end
        end
        if (m_mode) begin
            // Machine mode is only held back by locked regions.
            perm_x = !(found && sel_lock && !sel_x);
        end else begin
            perm_x = found && sel_x;
        end
    end

endmodule

// ==== logic/fetch_stage.sv ====
// Instruction fetch stage
`timescale 1ns/1ps

module fetch_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        fence_i,
    input  logic [1:0]  cur_priv,
    input  logic        fw_stall_if,
    input  logic        fw_exception,
    input  logic [31:2] fw_tvec,
    input  logic        fw_branch_correct,
    input  logic [31:1] fw_branch_alt,
    input  logic        fw_branch_predict,
    input  logic [31:1] fw_branch_target,
    input  logic        bus_ready,
    input  logic [31:0] buf_data   [fetch_pkg::fetch_buf_depth],
    input  logic [31:2] buf_addr   [fetch_pkg::fetch_buf_depth],
    input  logic        buf_valid  [fetch_pkg::fetch_buf_depth],
    input  logic        buf_m_mode [fetch_pkg::fetch_buf_depth],
    input  logic        buf_x      [fetch_pkg::fetch_buf_depth],
    output logic        bus_re,
    output logic [31:2] bus_addr,
    output logic        m_mode,
    output logic [31:1] next_pc,
    output logic        q_valid,
    output logic        q_trap,
    output logic [3:0]  q_cause,
    output logic [31:1] q_pc,
    output logic [31:0] q_insn
);

    logic [31:1] pc;
    logic [31:1] addr;
    logic [31:1] next_hw;
    logic [31:1] next_addr;
    logic [31:2] newest_addr;

    logic                  lo_hit;
    logic                  lo_x;
    fetch_pkg::insn_word_t lo_word;
    logic                  hi_hit;
    logic                  hi_x;
    fetch_pkg::insn_word_t hi_word;

    fetch_pkg::insn_word_t insn;
    logic                  is_32;
    logic                  insn_valid;
    logic                  perm_ok;

    assign m_mode  = cur_priv == 2'd3;
    assign next_pc = pc;

    // Lookup address, redirects take effect in the same cycle.
    always_comb begin
        if (fw_stall_if) begin
            addr = pc;
        end else if (fw_exception) begin
            addr = {fw_tvec, 1'b0};
        end else if (fw_branch_correct) begin
            addr = fw_branch_alt;
        end else if (fw_branch_predict) begin
            addr = fw_branch_target;
        end else begin
            addr = pc;
        end
    end

    assign next_hw = addr + 31'd1;

    fetch_buffer_reader u_read_lo (
        .m_mode      (m_mode),
        .buf_data    (buf_data),
        .buf_addr    (buf_addr),
        .buf_valid   (buf_valid),
        .buf_m_mode  (buf_m_mode),
        .buf_x       (buf_x),
        .lookup_addr (addr[31:2]),
        .hit         (lo_hit),
        .rdata       (lo_word),
        .perm_x      (lo_x)
    );

    // Word holding the second halfword.
    fetch_buffer_reader u_read_hi (
        .m_mode      (m_mode),
        .buf_data    (buf_data),
        .buf_addr    (buf_addr),
        .buf_valid   (buf_valid),
        .buf_m_mode  (buf_m_mode),
        .buf_x       (buf_x),
        .lookup_addr (next_hw[31:2]),
        .hit         (hi_hit),
        .rdata       (hi_word),
        .perm_x      (hi_x)
    );

    // Halfword assembly.
    always_comb begin
        insn.half.lo = addr[1] ? lo_word.half.hi : lo_word.half.lo;
        insn.half.hi = addr[1] ? hi_word.half.lo : hi_word.half.hi;
    end

    assign is_32      = insn.half.lo[1:0] == 2'b11;
    assign insn_valid = lo_hit && (!is_32 || hi_hit);
    assign perm_ok    = lo_x && (!is_32 || hi_x);
    assign next_addr  = addr + (is_32 ? 31'd2 : 31'd1);

    // Newest word in the buffer, entry 0 only if it arrived.
    assign newest_addr = bus_ready ? buf_addr[0] : buf_addr[1];

    // Bus request selection.
    always_comb begin
        bus_re   = 1'b1;
        bus_addr = newest_addr + 30'd1;
        if (rst || fence_i) begin
            bus_re   = 1'b0;
            bus_addr = addr[31:2];
        end else if (!lo_hit) begin
            bus_addr = addr[31:2];
        end else if (is_32 && !hi_hit) begin
            bus_addr = next_hw[31:2];
        end
    end

    // Output stage.
    always_comb begin
        q_valid = 1'b0;
        q_trap  = 1'b0;
        if (insn_valid && !clear && !fence_i) begin
            q_valid = perm_ok;
            q_trap  = !perm_ok;
        end
    end

    assign q_cause = q_trap ? fetch_pkg::ecause_iaccess : 4'd0;
    assign q_pc    = addr;
    assign q_insn  = insn.full;

    // Advance past a delivered instruction or latch the redirect.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= fetch_pkg::entry_point[31:1];
        end else if (!fw_stall_if) begin
            pc <= (q_valid || q_trap) ? next_addr : addr;
        end
    end

endmodule

// ==== logic/fetch_unit.sv ====
// Instruction fetch unit
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [1:0]                                  cur_priv,
    input  logic                                        clear,
    input  logic                                        fence_i,
    input  logic                                        fw_stall_if,
    input  logic                                        fw_exception,
    input  logic [31:2]                                 fw_tvec,
    input  logic                                        fw_branch_correct,
    input  logic [31:1]                                 fw_branch_alt,
    input  logic                                        fw_branch_predict,
    input  logic [31:1]                                 fw_branch_target,
    input  logic                                        cfg_we,
    input  logic [$clog2(fetch_pkg::pmp_regions)-1:0]   cfg_index,
    input  logic [31:2]                                 cfg_base,
    input  logic [31:2]                                 cfg_limit,
    input  logic                                        cfg_x,
    input  logic                                        cfg_lock,
    output logic                                        bus_re,
    output logic [31:2]                                 bus_addr,
    input  logic                                        bus_ready,
    input  logic [31:0]                                 bus_rdata,
    output logic                                        q_valid,
    output logic                                        q_trap,
    output logic [3:0]                                  q_cause,
    output logic [31:1]                                 q_pc,
    output logic [31:0]                                 q_insn,
    output logic [31:1]                                 next_pc
);

    logic        m_mode;
    logic        perm_x;
    logic [31:0] buf_data   [fetch_pkg::fetch_buf_depth];
    logic [31:2] buf_addr   [fetch_pkg::fetch_buf_depth];
    logic        buf_valid  [fetch_pkg::fetch_buf_depth];
    logic        buf_m_mode [fetch_pkg::fetch_buf_depth];
    logic        buf_x      [fetch_pkg::fetch_buf_depth];

    fetch_stage u_stage (
        .clk               (clk),
        .rst               (rst),
        .clear             (clear),
        .fence_i           (fence_i),
        .cur_priv          (cur_priv),
        .fw_stall_if       (fw_stall_if),
        .fw_exception      (fw_exception),
        .fw_tvec           (fw_tvec),
        .fw_branch_correct (fw_branch_correct),
        .fw_branch_alt     (fw_branch_alt),
        .fw_branch_predict (fw_branch_predict),
        .fw_branch_target  (fw_branch_target),
        .bus_ready         (bus_ready),
        .buf_data          (buf_data),
        .buf_addr          (buf_addr),
        .buf_valid         (buf_valid),
        .buf_m_mode        (buf_m_mode),
        .buf_x             (buf_x),
        .bus_re            (bus_re),
        .bus_addr          (bus_addr),
        .m_mode            (m_mode),
        .next_pc           (next_pc),
        .q_valid           (q_valid),
        .q_trap            (q_trap),
        .q_cause           (q_cause),
        .q_pc              (q_pc),
        .q_insn            (q_insn)
    );

    // Stores each returned word with the tags of its request.
    fetch_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .fence_i    (fence_i),
        .bus_ready  (bus_ready),
        .bus_rdata  (bus_rdata),
        .bus_addr   (bus_addr),
        .m_mode     (m_mode),
        .perm_x     (perm_x),
        .buf_data   (buf_data),
        .buf_addr   (buf_addr),
        .buf_valid  (buf_valid),
        .buf_m_mode (buf_m_mode),
        .buf_x      (buf_x)
    );

    // Checks the address being requested on the bus.
    exec_permission u_perm (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_index  (cfg_index),
        .cfg_base   (cfg_base),
        .cfg_limit  (cfg_limit),
        .cfg_x      (cfg_x),
        .cfg_lock   (cfg_lock),
        .m_mode     (m_mode),
        .check_addr (bus_addr),
        .perm_x     (perm_x)
    );

endmodule

// ==== tb/fetch_unit_checker.sv ====
// Fetch protocol assertions
`timescale 1ns/1ps

module fetch_unit_checker (
    input logic        clk,
    input logic        rst,
    input logic        bus_re,
    input logic        q_valid,
    input logic        q_trap,
    input logic        fw_stall_if,
    input logic [31:1] q_pc
);

    // An instruction is either delivered or trapped, never both.
    valid_trap_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(q_valid && q_trap)
    ) else $error("q_valid and q_trap are high in the same cycle");

    // No bus request while in reset.
    no_request_in_reset: assert property (
        @(posedge clk)
        rst |-> !bus_re
    ) else $error("bus_re is high during reset");

    // The pc seen at the output does not move while stalled.
    pc_held_in_stall: assert property (
        @(posedge clk) disable iff (rst)
        fw_stall_if ##1 fw_stall_if |-> q_pc == $past(q_pc)
    ) else $error("q_pc changed while fw_stall_if was held");

endmodule

// ==== tb/fetch_unit_tb.sv ====
// Fetch unit testbench
`timescale 1ns/1ps

module fetch_unit_tb;

    localparam int mem_words = 1024;

    logic        clk;
    logic        rst;
    logic [1:0]  cur_priv;
    logic        clear;
    logic        fence_i;
    logic        fw_stall_if;
    logic        fw_exception;
    logic [31:2] fw_tvec;
    logic        fw_branch_correct;
    logic [31:1] fw_branch_alt;
    logic        fw_branch_predict;
    logic [31:1] fw_branch_target;
    logic        cfg_we;
    logic [1:0]  cfg_index;
    logic [31:2] cfg_base;
    logic [31:2] cfg_limit;
    logic        cfg_x;
    logic        cfg_lock;
    logic        bus_re;
    logic [31:2] bus_addr;
    logic        bus_ready;
    logic [31:0] bus_rdata;
    logic        q_valid;
    logic        q_trap;
    logic [3:0]  q_cause;
    logic [31:1] q_pc;
    logic [31:0] q_insn;
    logic [31:1] next_pc;

    // Program memory and a copy of the region table.
    fetch_pkg::insn_word_t mem [mem_words];
    logic [31:2] rg_base  [fetch_pkg::pmp_regions];
    logic [31:2] rg_limit [fetch_pkg::pmp_regions];
    logic        rg_en    [fetch_pkg::pmp_regions];
    logic        rg_x     [fetch_pkg::pmp_regions];
    logic        rg_lock  [fetch_pkg::pmp_regions];

    int          errors;
    int          timeouts;
    int          accepted;
    int          traps;
    int          trap_base;
    string       test_name;
    logic [31:1] exp_pc;

    fetch_unit DUT (
        .clk               (clk),
        .rst               (rst),
        .cur_priv          (cur_priv),
        .clear             (clear),
        .fence_i           (fence_i),
        .fw_stall_if       (fw_stall_if),
        .fw_exception      (fw_exception),
        .fw_tvec           (fw_tvec),
        .fw_branch_correct (fw_branch_correct),
        .fw_branch_alt     (fw_branch_alt),
        .fw_branch_predict (fw_branch_predict),
        .fw_branch_target  (fw_branch_target),
        .cfg_we            (cfg_we),
        .cfg_index         (cfg_index),
        .cfg_base          (cfg_base),
        .cfg_limit         (cfg_limit),
        .cfg_x             (cfg_x),
        .cfg_lock          (cfg_lock),
        .bus_re            (bus_re),
        .bus_addr          (bus_addr),
        .bus_ready         (bus_ready),
        .bus_rdata         (bus_rdata),
        .q_valid           (q_valid),
        .q_trap            (q_trap),
        .q_cause           (q_cause),
        .q_pc              (q_pc),
        .q_insn            (q_insn),
        .next_pc           (next_pc)
    );

    bind fetch_unit fetch_unit_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .bus_re      (bus_re),
        .q_valid     (q_valid),
        .q_trap      (q_trap),
        .fw_stall_if (fw_stall_if),
        .q_pc        (q_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory answers one cycle after the request, sometimes not at all.
    always @(posedge clk) begin
        if (rst || !bus_re) begin
            bus_ready <= 1'b0;
        end else begin
            bus_ready <= ($urandom % 4) != 0;
            bus_rdata <= mem[bus_addr[11:2]].full;
        end
    end

    // Random halfword, about one in three opens a 32-bit instruction.
    function automatic logic [15:0] rand_half();
        logic [15:0] h;
        h = 16'($urandom);
        if ($urandom % 3 == 0) begin
            h[1:0] = 2'b11;
        end else if (h[1:0] == 2'b11) begin
            h[1:0] = 2'b10;
        end
        return h;
    endfunction

    function automatic logic [31:1] rand_hw();
        return 31'($urandom % (2 * mem_words));
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < mem_words; i++) begin
            mem[i].half.lo = rand_half();
            mem[i].half.hi = rand_half();
        end
    endtask

    // First matching region decides, M-mode only stops at locked ones.
    function automatic logic word_allowed(input logic [31:2] wa, input logic mm);
        logic found;
        logic sx;
        logic sl;
        found = 1'b0;
        sx    = 1'b0;
        sl    = 1'b0;
        for (int i = 0; i < fetch_pkg::pmp_regions; i++) begin
            if (!found && rg_en[i] && wa >= rg_base[i] && wa <= rg_limit[i]) begin
                found = 1'b1;
                sx    = rg_x[i];
                sl    = rg_lock[i];
            end
        end
        return mm ? !(found && sl && !sx) : (found && sx);
    endfunction

    // Expected instruction, length in halfwords and permission at pc.
    function automatic fetch_pkg::insn_word_t ref_fetch(input logic [31:1] pc,
                                                        output int len, output logic ok);
        fetch_pkg::insn_word_t w0;
        fetch_pkg::insn_word_t w1;
        fetch_pkg::insn_word_t r;
        logic [31:1]           pn;
        logic                  mm;
        pn = pc + 31'd1;
        w0 = mem[pc[11:2]];
        w1 = mem[pn[11:2]];
        r.half.lo = pc[1] ? w0.half.hi : w0.half.lo;
        r.half.hi = pn[1] ? w1.half.hi : w1.half.lo;
        len = (r.half.lo[1:0] == 2'b11) ? 2 : 1;
        mm  = cur_priv == 2'd3;
        ok  = word_allowed(pc[31:2], mm) && (len == 1 || word_allowed(pn[31:2], mm));
        return r;
    endfunction

    task automatic check_insn(input string what, input fetch_pkg::insn_word_t exp,
                              input fetch_pkg::insn_word_t act);
        logic bad;
        if (exp.half.lo[1:0] == 2'b11) begin
            bad = exp.full !== act.full;
        end else begin
            bad = exp.half.lo !== act.half.lo;
        end
        if (bad) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp.full, act.full);
            errors++;
        end
    endtask

    task automatic check_pc(input string what, input logic [31:1] exp, input logic [31:1] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_trap(input string what, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // Follows the expected pc and checks every accepted output.
    always @(negedge clk) begin
        fetch_pkg::insn_word_t exp_insn;
        logic [31:1]           eff;
        int                    len;
        logic                  ok;
        if (rst) begin
            exp_pc = fetch_pkg::entry_point[31:1];
        end else begin
            // The pc register holds the next instruction still to be taken.
            check_pc("next_pc", exp_pc, next_pc);
            if (!fw_stall_if) begin
                eff = exp_pc;
                if (fw_exception) begin
                    eff = {fw_tvec, 1'b0};
                end else if (fw_branch_correct) begin
                    eff = fw_branch_alt;
                end else if (fw_branch_predict) begin
                    eff = fw_branch_target;
                end
                exp_pc = eff;
                if (q_valid || q_trap) begin
                    exp_insn = ref_fetch(eff, len, ok);
                    check_pc("pc", eff, q_pc);
                    check_trap("cause", ok ? 4'd0 : fetch_pkg::ecause_iaccess, q_cause);
                    if (q_valid) begin
                        check_insn("insn", exp_insn, q_insn);
                    end
                    if (q_trap) begin
                        traps++;
                    end
                    exp_pc = eff + 31'(len);
                    accepted++;
                end
            end
        end
    end

    task automatic wait_accepts(input int n, input int limit);
        int target;
        int cycles;
        target = accepted + n;
        cycles = 0;
        while (accepted < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (accepted < target) begin
            $display("Timeout in %s: %0d of %0d instructions delivered in %0d cycles",
                     test_name, n - (target - accepted), n, limit);
            timeouts++;
        end
    endtask

    task automatic redirect(input logic exc, input logic corr, input logic pred,
                            input logic [31:1] tvec_hw, input logic [31:1] alt,
                            input logic [31:1] tgt);
        @(posedge clk);
        fw_stall_if       <= 1'b0;
        fw_exception      <= exc;
        fw_tvec           <= tvec_hw[31:2];
        fw_branch_correct <= corr;
        fw_branch_alt     <= alt;
        fw_branch_predict <= pred;
        fw_branch_target  <= tgt;
        @(posedge clk);
        fw_exception      <= 1'b0;
        fw_branch_correct <= 1'b0;
        fw_branch_predict <= 1'b0;
    endtask

    task automatic write_region(input int idx, input logic [31:2] base,
                                input logic [31:2] limit, input logic x, input logic lock);
        @(posedge clk);
        cfg_we        <= 1'b1;
        cfg_index     <= 2'(idx);
        cfg_base      <= base;
        cfg_limit     <= limit;
        cfg_x         <= x;
        cfg_lock      <= lock;
        rg_en[idx]    = 1'b1;
        rg_base[idx]  = base;
        rg_limit[idx] = limit;
        rg_x[idx]     = x;
        rg_lock[idx]  = lock;
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic hold_fetch();
        @(posedge clk);
        fw_stall_if <= 1'b1;
    endtask

    // Empties the buffer while the stage is held.
    task automatic flush_buffer();
        repeat (2) @(posedge clk);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic expect_traps();
        if (traps == trap_base) begin
            $display("No instruction access trap was raised in %s", test_name);
            errors++;
        end
        trap_base = traps;
    endtask

    initial begin
        void'($urandom(32'hdc20));
        rst               = 1'b1;
        cur_priv          = 2'd3;
        clear             = 1'b0;
        fence_i           = 1'b0;
        fw_stall_if       = 1'b0;
        fw_exception      = 1'b0;
        fw_tvec           = '0;
        fw_branch_correct = 1'b0;
        fw_branch_alt     = '0;
        fw_branch_predict = 1'b0;
        fw_branch_target  = '0;
        cfg_we            = 1'b0;
        cfg_index         = '0;
        cfg_base          = '0;
        cfg_limit         = '0;
        cfg_x             = 1'b0;
        cfg_lock          = 1'b0;
        bus_ready         = 1'b0;
        bus_rdata         = '0;
        errors            = 0;
        timeouts          = 0;
        accepted          = 0;
        traps             = 0;
        trap_base         = 0;
        for (int i = 0; i < fetch_pkg::pmp_regions; i++) begin
            rg_en[i] = 1'b0;
        end
        fill_memory();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        test_name = "sequential";
        wait_accepts(80, 1000);

        test_name = "stall";
        repeat (200) begin
            @(posedge clk);
            fw_stall_if <= ($urandom % 3) == 0;
        end
        @(posedge clk);
        fw_stall_if <= 1'b0;
        wait_accepts(10, 200);

        test_name = "redirect";
        redirect(1'b1, 1'b0, 1'b0, rand_hw(), '0, '0);
        wait_accepts(12, 300);
        redirect(1'b0, 1'b1, 1'b0, '0, rand_hw(), '0);
        wait_accepts(12, 300);
        redirect(1'b0, 1'b0, 1'b1, '0, '0, rand_hw());
        wait_accepts(12, 300);
        redirect(1'b1, 1'b1, 1'b1, rand_hw(), rand_hw(), rand_hw());
        wait_accepts(12, 300);
        redirect(1'b0, 1'b1, 1'b1, '0, rand_hw(), rand_hw());
        wait_accepts(12, 300);

        // User mode, with a 32-bit instruction across the region edge.
        test_name = "user_perm";
        hold_fetch();
        cur_priv <= 2'd0;
        write_region(0, 30'h000, 30'h0FF, 1'b1, 1'b0);
        write_region(1, 30'h100, 30'h1FF, 1'b0, 1'b0);
        write_region(2, 30'h200, 30'h27F, 1'b0, 1'b1);
        mem[10'h0FF].half.hi[1:0] = 2'b11;
        flush_buffer();
        trap_base = traps;
        redirect(1'b0, 1'b1, 1'b0, '0, 31'h1FF, '0);
        wait_accepts(8, 300);
        expect_traps();
        redirect(1'b1, 1'b0, 1'b0, 31'h040, '0, '0);
        wait_accepts(12, 300);

        test_name = "machine_perm";
        hold_fetch();
        cur_priv <= 2'd3;
        flush_buffer();
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 31'h3F8);
        wait_accepts(20, 400);
        expect_traps();

        test_name = "fence_i";
        redirect(1'b1, 1'b0, 1'b0, 31'h0A0, '0, '0);
        wait_accepts(10, 300);
        // Rewrite memory under the buffered words, then flush and resume in place.
        hold_fetch();
        fill_memory();
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i     <= 1'b0;
        fw_stall_if <= 1'b0;
        wait_accepts(30, 500);

        repeat (4) @(posedge clk);
        $display("Run complete: %0d errors, %0d timeouts, %0d instructions checked",
                 errors, timeouts, accepted);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== fetch_unit.f ====
logic/fetch_pkg.sv
logic/fetch_buffer.sv
logic/fetch_buffer_reader.sv
logic/exec_permission.sv
logic/fetch_stage.sv
logic/fetch_unit.sv
tb/fetch_unit_checker.sv
tb/fetch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_buffer.sv
  - logic/fetch_buffer_reader.sv
  - logic/exec_permission.sv
  - logic/fetch_stage.sv
  - logic/fetch_unit.sv
  - target: test
    files:
      - tb/fetch_unit_checker.sv
      - tb/fetch_unit_tb.sv
